//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int MASK_W = DATA_W / 8;  // one bit per byte lane

  // region select field of the address
  localparam int REGION_MSB = 31;
  localparam int REGION_LSB = 30;

  localparam logic [REGION_MSB-REGION_LSB:0] REGION_RAM = 2'b00;
  localparam logic [REGION_MSB-REGION_LSB:0] REGION_LED = 2'b10;
  localparam logic [REGION_MSB-REGION_LSB:0] REGION_KEY = 2'b11;

  localparam int WORD_LSB = 2;  // byte offset below this bit

endpackage

`default_nettype wire

//--- src/bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
  input  logic                       clk,
  input  logic                       i_rst_n,

  input  logic                       i_ibus_req,
  input  logic [bus_pkg::ADDR_W-1:0] i_ibus_addr,
  output logic                       o_ibus_ack,
  output logic [bus_pkg::DATA_W-1:0] o_ibus_data,

  input  logic                       i_dbus_req,
  input  logic                       i_dbus_write,
  input  logic [bus_pkg::ADDR_W-1:0] i_dbus_addr,
  input  logic [bus_pkg::DATA_W-1:0] i_dbus_data,
  input  logic [bus_pkg::MASK_W-1:0] i_dbus_rd_mask,
  input  logic [bus_pkg::MASK_W-1:0] i_dbus_wr_mask,
  output logic                       o_dbus_ack,
  output logic [bus_pkg::DATA_W-1:0] o_dbus_data,

  input  logic                       i_sh_ack,
  input  logic [bus_pkg::DATA_W-1:0] i_sh_rdata,
  output logic                       o_sh_req,
  output logic                       o_sh_write,
  output logic [bus_pkg::ADDR_W-1:0] o_sh_addr,
  output logic [bus_pkg::DATA_W-1:0] o_sh_wdata,
  output logic [bus_pkg::MASK_W-1:0] o_sh_rd_mask,
  output logic [bus_pkg::MASK_W-1:0] o_sh_wr_mask
);
  import bus_pkg::*;

  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_BUSY    = 2'd1;
  localparam logic [1:0] ST_RELEASE = 2'd2;

  logic [1:0] state;
  logic       gnt_dbus;   // current owner, last winner while idle
  logic       pick_dbus;
  logic       done;

  // on a tie the port that lost last time goes first
  assign pick_dbus = i_dbus_req & (~i_ibus_req | ~gnt_dbus);
  assign done      = (state == ST_BUSY) & i_sh_ack;

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      state    <= ST_IDLE;
      gnt_dbus <= 1'b0;  // dbus wins the first tie
      o_sh_req <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (i_ibus_req | i_dbus_req)
          begin
            state    <= ST_BUSY;
            gnt_dbus <= pick_dbus;
            o_sh_req <= 1'b1;
          end
        end
        ST_BUSY:
        begin
          if (i_sh_ack)
          begin
            state    <= ST_RELEASE;
            o_sh_req <= 1'b0;
          end
        end
        default:
          state <= ST_IDLE;  // one dead cycle so the master can drop req
      endcase
    end
  end

  // request fields are frozen once we leave idle
  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE)
    begin
      if (pick_dbus)
      begin
        o_sh_write   <= i_dbus_write;
        o_sh_addr    <= i_dbus_addr;
        o_sh_wdata   <= i_dbus_data;
        o_sh_rd_mask <= i_dbus_rd_mask;
        o_sh_wr_mask <= i_dbus_wr_mask;
      end
      else
      begin
        o_sh_write   <= 1'b0;  // fetch is read only
        o_sh_addr    <= i_ibus_addr;
        o_sh_wdata   <= '0;
        o_sh_rd_mask <= {MASK_W{1'b1}};
        o_sh_wr_mask <= '0;
      end
    end
  end

  assign o_ibus_ack  = done & ~gnt_dbus;
  assign o_dbus_ack  = done & gnt_dbus;
  assign o_ibus_data = o_ibus_ack ? i_sh_rdata : {DATA_W{1'b0}};
  assign o_dbus_data = o_dbus_ack ? i_sh_rdata : {DATA_W{1'b0}};

endmodule

`default_nettype wire

//--- src/bus_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module bus_decoder (
  input  logic                       clk,
  input  logic                       i_rst_n,

  input  logic                       i_sh_req,
  input  logic [bus_pkg::ADDR_W-1:0] i_sh_addr,
  input  logic [bus_pkg::MASK_W-1:0] i_sh_rd_mask,
  output logic                       o_sh_ack,
  output logic [bus_pkg::DATA_W-1:0] o_sh_rdata,

  output logic                       o_ram_req,
  input  logic                       i_ram_ack,
  input  logic [bus_pkg::DATA_W-1:0] i_ram_rdata,

  output logic                       o_led_req,
  input  logic                       i_led_ack,
  input  logic [bus_pkg::DATA_W-1:0] i_led_rdata,

  output logic                       o_key_req,
  input  logic                       i_key_ack,
  input  logic [bus_pkg::DATA_W-1:0] i_key_rdata
);
  import bus_pkg::*;

  localparam int BYTE_W = DATA_W / MASK_W;

  logic [REGION_MSB-REGION_LSB:0] region;
  logic                           unm_sel;
  logic                           unm_ack;
  logic                           sel_ack;
  logic [DATA_W-1:0]              sel_rdata;

  assign region = i_sh_addr[REGION_MSB:REGION_LSB];

  assign o_ram_req = i_sh_req & (region == REGION_RAM);
  assign o_led_req = i_sh_req & (region == REGION_LED);
  assign o_key_req = i_sh_req & (region == REGION_KEY);
  assign unm_sel   = (region != REGION_RAM) & (region != REGION_LED) &
                     (region != REGION_KEY);

  // stand-in target for the hole in the map
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      unm_ack <= 1'b0;
    else
      unm_ack <= i_sh_req & unm_sel & ~unm_ack;
  end

  always_comb
  begin
    case (region)
      REGION_RAM:
      begin
        sel_ack   = i_ram_ack;
        sel_rdata = i_ram_rdata;
      end
      REGION_LED:
      begin
        sel_ack   = i_led_ack;
        sel_rdata = i_led_rdata;
      end
      REGION_KEY:
      begin
        sel_ack   = i_key_ack;
        sel_rdata = i_key_rdata;
      end
      default:
      begin
        sel_ack   = unm_ack;
        sel_rdata = '0;
      end
    endcase
  end

  always_comb
  begin
    for (int b = 0; b < MASK_W; b++)
      o_sh_rdata[b*BYTE_W +: BYTE_W] = i_sh_rd_mask[b] ? sel_rdata[b*BYTE_W +: BYTE_W] : '0;
  end

  assign o_sh_ack = sel_ack;

endmodule

`default_nettype wire

//--- src/soc_ram.sv
`timescale 1ns/10ps
`default_nettype none

module soc_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic                       i_req,
  input  logic                       i_write,
  input  logic [bus_pkg::ADDR_W-1:0] i_addr,
  input  logic [bus_pkg::DATA_W-1:0] i_wdata,
  input  logic [bus_pkg::MASK_W-1:0] i_wr_mask,
  output logic                       o_ack,
  output logic [bus_pkg::DATA_W-1:0] o_rdata
);
  import bus_pkg::*;

  localparam int IDX_W  = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int BYTE_W = DATA_W / MASK_W;

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [ADDR_W-1:0] word_num;
  logic [IDX_W-1:0]  idx;
  logic              access;

  assign word_num = (i_addr >> WORD_LSB) % ADDR_W'(RAM_WORDS);  // wraps around
  assign idx      = word_num[IDX_W-1:0];
  assign access   = i_req & ~o_ack;  // one shot per request

  always_ff @(posedge clk)
  begin
    if (access & i_write)
    begin
      for (int b = 0; b < MASK_W; b++)
      begin
        if (i_wr_mask[b])
          mem[idx][b*BYTE_W +: BYTE_W] <= i_wdata[b*BYTE_W +: BYTE_W];
      end
    end
    if (access)
      o_rdata <= mem[idx];
  end

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      o_ack <= 1'b0;
    else
      o_ack <= access;
  end

endmodule

`default_nettype wire

//--- src/led_reg.sv
`timescale 1ns/10ps
`default_nettype none

module led_reg #(
  parameter int LED_W = 8
) (
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic                       i_req,
  input  logic                       i_write,
  input  logic [bus_pkg::DATA_W-1:0] i_wdata,
  input  logic [bus_pkg::MASK_W-1:0] i_wr_mask,
  output logic                       o_ack,
  output logic [bus_pkg::DATA_W-1:0] o_rdata,
  output logic [LED_W-1:0]           o_led
);
  import bus_pkg::*;

  logic [LED_W-1:0] led_q;
  logic             access;

  assign access = i_req & ~o_ack;

  // offset is ignored, whole region aliases one register
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      o_ack <= 1'b0;
      led_q <= '0;
    end
    else
    begin
      o_ack <= access;
      if (access & i_write & i_wr_mask[0])
        led_q <= i_wdata[LED_W-1:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (access)
      o_rdata <= {{(DATA_W-LED_W){1'b0}}, led_q};
  end

  assign o_led = led_q;

endmodule

`default_nettype wire

//--- src/key_port.sv
`timescale 1ns/10ps
`default_nettype none

module key_port #(
  parameter int KEY_W = 2
) (
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic                       i_req,
  input  logic                       i_write,
  input  logic [bus_pkg::DATA_W-1:0] i_wdata,
  input  logic [bus_pkg::MASK_W-1:0] i_wr_mask,
  input  logic [KEY_W-1:0]           i_key,
  output logic                       o_ack,
  output logic [bus_pkg::DATA_W-1:0] o_rdata
);
  import bus_pkg::*;

  logic [KEY_W-1:0] sync_1;
  logic [KEY_W-1:0] sync_2;   // settled level
  logic [KEY_W-1:0] key_d;    // level one cycle back
  logic [KEY_W-1:0] flags;
  logic [KEY_W-1:0] rise;
  logic [KEY_W-1:0] clr;
  logic             access;

  assign access = i_req & ~o_ack;
  assign rise   = sync_2 & ~key_d;
  assign clr    = (access & i_write & i_wr_mask[0]) ? i_wdata[2*KEY_W-1:KEY_W] : '0;

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      sync_1 <= '0;
      sync_2 <= '0;
      key_d  <= '0;
      flags  <= '0;
      o_ack  <= 1'b0;
    end
    else
    begin
      sync_1 <= i_key;
      sync_2 <= sync_1;
      key_d  <= sync_2;
      flags  <= (flags & ~clr) | rise;  // a new press beats a clear
      o_ack  <= access;
    end
  end

  always_ff @(posedge clk)
  begin
    if (access)
      o_rdata <= {{(DATA_W-2*KEY_W){1'b0}}, flags, sync_2};
  end

endmodule

`default_nettype wire

//--- src/soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_top #(
  parameter int RAM_WORDS = 256,
  parameter int LED_W     = 8,
  parameter int KEY_W     = 2
) (
  input  logic                       clk,
  input  logic                       i_rst_n,

  input  logic                       i_ibus_req,
  input  logic [bus_pkg::ADDR_W-1:0] i_ibus_addr,
  output logic                       o_ibus_ack,
  output logic [bus_pkg::DATA_W-1:0] o_ibus_data,

  input  logic                       i_dbus_req,
  input  logic                       i_dbus_write,
  input  logic [bus_pkg::ADDR_W-1:0] i_dbus_addr,
  input  logic [bus_pkg::DATA_W-1:0] i_dbus_data,
  input  logic [bus_pkg::MASK_W-1:0] i_dbus_rd_mask,
  input  logic [bus_pkg::MASK_W-1:0] i_dbus_wr_mask,
  output logic                       o_dbus_ack,
  output logic [bus_pkg::DATA_W-1:0] o_dbus_data,

  input  logic [KEY_W-1:0]           i_key,
  output logic [LED_W-1:0]           o_led
);

  logic                       sh_req;
  logic                       sh_write;
  logic [bus_pkg::ADDR_W-1:0] sh_addr;
  logic [bus_pkg::DATA_W-1:0] sh_wdata;
  logic [bus_pkg::MASK_W-1:0] sh_rd_mask;
  logic [bus_pkg::MASK_W-1:0] sh_wr_mask;
  logic                       sh_ack;
  logic [bus_pkg::DATA_W-1:0] sh_rdata;

  logic                       ram_req;
  logic                       ram_ack;
  logic [bus_pkg::DATA_W-1:0] ram_rdata;
  logic                       led_req;
  logic                       led_ack;
  logic [bus_pkg::DATA_W-1:0] led_rdata;
  logic                       key_req;
  logic                       key_ack;
  logic [bus_pkg::DATA_W-1:0] key_rdata;

  bus_arbiter arbiter_i (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_ibus_req     (i_ibus_req),
    .i_ibus_addr    (i_ibus_addr),
    .o_ibus_ack     (o_ibus_ack),
    .o_ibus_data    (o_ibus_data),
    .i_dbus_req     (i_dbus_req),
    .i_dbus_write   (i_dbus_write),
    .i_dbus_addr    (i_dbus_addr),
    .i_dbus_data    (i_dbus_data),
    .i_dbus_rd_mask (i_dbus_rd_mask),
    .i_dbus_wr_mask (i_dbus_wr_mask),
    .o_dbus_ack     (o_dbus_ack),
    .o_dbus_data    (o_dbus_data),
    .i_sh_ack       (sh_ack),
    .i_sh_rdata     (sh_rdata),
    .o_sh_req       (sh_req),
    .o_sh_write     (sh_write),
    .o_sh_addr      (sh_addr),
    .o_sh_wdata     (sh_wdata),
    .o_sh_rd_mask   (sh_rd_mask),
    .o_sh_wr_mask   (sh_wr_mask)
  );

  bus_decoder decoder_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_sh_req     (sh_req),
    .i_sh_addr    (sh_addr),
    .i_sh_rd_mask (sh_rd_mask),
    .o_sh_ack     (sh_ack),
    .o_sh_rdata   (sh_rdata),
    .o_ram_req    (ram_req),
    .i_ram_ack    (ram_ack),
    .i_ram_rdata  (ram_rdata),
    .o_led_req    (led_req),
    .i_led_ack    (led_ack),
    .i_led_rdata  (led_rdata),
    .o_key_req    (key_req),
    .i_key_ack    (key_ack),
    .i_key_rdata  (key_rdata)
  );

  // write side of the bus fans out to all targets directly
  soc_ram #(.RAM_WORDS(RAM_WORDS)) ram_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_req     (ram_req),
    .i_write   (sh_write),
    .i_addr    (sh_addr),
    .i_wdata   (sh_wdata),
    .i_wr_mask (sh_wr_mask),
    .o_ack     (ram_ack),
    .o_rdata   (ram_rdata)
  );

  led_reg #(.LED_W(LED_W)) led_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_req     (led_req),
    .i_write   (sh_write),
    .i_wdata   (sh_wdata),
    .i_wr_mask (sh_wr_mask),
    .o_ack     (led_ack),
    .o_rdata   (led_rdata),
    .o_led     (o_led)
  );

  key_port #(.KEY_W(KEY_W)) key_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_req     (key_req),
    .i_write   (sh_write),
    .i_wdata   (sh_wdata),
    .i_wr_mask (sh_wr_mask),
    .i_key     (i_key),
    .o_ack     (key_ack),
    .o_rdata   (key_rdata)
  );

endmodule

`default_nettype wire

//--- tb/tb_soc_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_soc_top;
  import bus_pkg::*;

  localparam int RAM_WORDS   = 256;
  localparam int LED_W       = 8;
  localparam int KEY_W       = 2;
  localparam int ACK_TIMEOUT = 40;  // cycles per wait loop

  logic              clk;
  logic              rst_n;
  logic              ibus_req;
  logic [ADDR_W-1:0] ibus_addr;
  logic              ibus_ack;
  logic [DATA_W-1:0] ibus_data;
  logic              dbus_req;
  logic              dbus_write;
  logic [ADDR_W-1:0] dbus_addr;
  logic [DATA_W-1:0] dbus_wdata;
  logic [MASK_W-1:0] dbus_rd_mask;
  logic [MASK_W-1:0] dbus_wr_mask;
  logic              dbus_ack;
  logic [DATA_W-1:0] dbus_data;
  logic [KEY_W-1:0]  key;
  logic [LED_W-1:0]  led;

  int checks;
  int errors;
  int timeouts;

  // one queued read per port for the next tie round
  logic              tie_d_set;
  logic [ADDR_W-1:0] tie_d_addr;
  logic [MASK_W-1:0] tie_d_rmask;
  logic [DATA_W-1:0] tie_d_exp;
  logic              tie_i_set;
  logic [ADDR_W-1:0] tie_i_addr;
  logic [DATA_W-1:0] tie_i_exp;

  soc_top #(
    .RAM_WORDS (RAM_WORDS),
    .LED_W     (LED_W),
    .KEY_W     (KEY_W)
  ) dut_i (
    .clk            (clk),
    .i_rst_n        (rst_n),
    .i_ibus_req     (ibus_req),
    .i_ibus_addr    (ibus_addr),
    .o_ibus_ack     (ibus_ack),
    .o_ibus_data    (ibus_data),
    .i_dbus_req     (dbus_req),
    .i_dbus_write   (dbus_write),
    .i_dbus_addr    (dbus_addr),
    .i_dbus_data    (dbus_wdata),
    .i_dbus_rd_mask (dbus_rd_mask),
    .i_dbus_wr_mask (dbus_wr_mask),
    .o_dbus_ack     (dbus_ack),
    .o_dbus_data    (dbus_data),
    .i_key          (key),
    .o_led          (led)
  );

  always #4 clk = ~clk;

  function automatic string port_name(input logic on_dbus);
    return on_dbus ? "data" : "instruction";
  endfunction

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // one transaction on one port, req held until its ack
  task automatic bus_access(input logic on_dbus, input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [MASK_W-1:0] rmask,
                            input logic [MASK_W-1:0] wmask, output logic [DATA_W-1:0] rdata,
                            output logic acked);
    int cnt;
    cnt   = 0;
    acked = 1'b0;
    rdata = '0;
    @(posedge clk);
    if (on_dbus)
    begin
      dbus_req     <= 1'b1;
      dbus_write   <= wr;
      dbus_addr    <= addr;
      dbus_wdata   <= data;
      dbus_rd_mask <= rmask;
      dbus_wr_mask <= wmask;
    end
    else
    begin
      ibus_req  <= 1'b1;
      ibus_addr <= addr;
    end
    while (!acked && cnt < ACK_TIMEOUT)
    begin
      @(negedge clk);
      if (on_dbus ? ibus_ack : dbus_ack)
      begin
        errors++;
        $display("ack on the %s port, which made no request", port_name(!on_dbus));
      end
      if (on_dbus ? dbus_ack : ibus_ack)
      begin
        acked = 1'b1;
        rdata = on_dbus ? dbus_data : ibus_data;
      end
      cnt++;
    end
    if (!acked)
    begin
      errors++;
      timeouts++;
      $display("timeout: no ack on the %s port for address %h", port_name(on_dbus), addr);
    end
    @(posedge clk);
    ibus_req   <= 1'b0;
    dbus_req   <= 1'b0;
    dbus_write <= 1'b0;
  endtask

  // both ports raise req in the same cycle
  task automatic tie_round(input logic ibus_first);
    int                cnt;
    logic              d_done;
    logic              i_done;
    logic              i_won;
    logic [DATA_W-1:0] d_got;
    logic [DATA_W-1:0] i_got;
    cnt    = 0;
    d_done = 1'b0;
    i_done = 1'b0;
    i_won  = 1'b0;
    d_got  = '0;
    i_got  = '0;
    @(posedge clk);
    dbus_req     <= 1'b1;
    dbus_write   <= 1'b0;
    dbus_addr    <= tie_d_addr;
    dbus_rd_mask <= tie_d_rmask;
    dbus_wr_mask <= '0;
    ibus_req     <= 1'b1;
    ibus_addr    <= tie_i_addr;
    while (!(d_done && i_done) && cnt < ACK_TIMEOUT)
    begin
      @(negedge clk);
      if (dbus_ack && d_done)
      begin
        errors++;
        $display("second ack on the data port for one request");
      end
      else if (dbus_ack)
      begin
        d_done = 1'b1;
        d_got  = dbus_data;
      end
      if (ibus_ack && i_done)
      begin
        errors++;
        $display("second ack on the instruction port for one request");
      end
      else if (ibus_ack)
      begin
        i_done = 1'b1;
        i_got  = ibus_data;
        i_won  = !d_done;
      end
      @(posedge clk);
      if (d_done)
        dbus_req <= 1'b0;
      if (i_done)
        ibus_req <= 1'b0;
      cnt++;
    end
    dbus_req <= 1'b0;
    ibus_req <= 1'b0;
    if (!(d_done && i_done))
    begin
      errors++;
      timeouts++;
      $display("timeout in a tie round: data port acked %0d, instruction port acked %0d",
               d_done, i_done);
    end
    if (d_done)
      check_value("o_dbus_data", d_got, tie_d_exp);
    if (i_done)
      check_value("o_ibus_data", i_got, tie_i_exp);
    if (d_done && i_done)
      check_value("first grant to instruction port", DATA_W'(i_won), DATA_W'(ibus_first));
  endtask

  task automatic run_test_line(input string line, input int line_no);
    int                fields;
    logic [7:0]        act;
    logic [7:0]        port;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] rmask;
    logic [MASK_W-1:0] wmask;
    logic [DATA_W-1:0] exp;
    logic [DATA_W-1:0] rdata;
    logic              acked;
    fields = $sscanf(line, "%c %c %h %h %h %h %h", act, port, addr, data, rmask, wmask, exp);
    if (fields != 7)
    begin
      errors++;
      $display("line %0d of the test file could not be read", line_no);
    end
    else
    begin
      case (act)
        "w":
        begin
          if (port != "d")
          begin
            errors++;
            $display("line %0d asks for a write on the instruction port", line_no);
          end
          else
            bus_access(1'b1, 1'b1, addr, data, rmask, wmask, rdata, acked);
        end
        "r":
        begin
          bus_access(port == "d", 1'b0, addr, '0, rmask, '0, rdata, acked);
          if (acked)
            check_value(port == "d" ? "o_dbus_data" : "o_ibus_data", rdata, exp);
        end
        "k":
        begin
          @(posedge clk);
          key <= data[KEY_W-1:0];
          repeat (4) @(posedge clk);  // two sync flops and the edge detect
        end
        "o":
        begin
          @(negedge clk);
          check_value("o_led", DATA_W'(led), exp);
        end
        "q":
        begin
          if (port == "d")
          begin
            tie_d_set   = 1'b1;
            tie_d_addr  = addr;
            tie_d_rmask = rmask;
            tie_d_exp   = exp;
          end
          else
          begin
            tie_i_set  = 1'b1;
            tie_i_addr = addr;
            tie_i_exp  = exp;
          end
        end
        "g":
        begin
          if (!tie_d_set || !tie_i_set)
          begin
            errors++;
            $display("line %0d starts a tie round without a read queued on both ports", line_no);
          end
          else
            tie_round(port == "i");
          tie_d_set = 1'b0;
          tie_i_set = 1'b0;
        end
        default:
        begin
          errors++;
          $display("line %0d has an unknown action", line_no);
        end
      endcase
    end
  endtask

  initial
  begin
    int    fd;
    int    line_no;
    logic  at_end;
    string line;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    line_no      = 0;
    at_end       = 1'b0;
    tie_d_set    = 1'b0;
    tie_i_set    = 1'b0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    ibus_req     = 1'b0;
    ibus_addr    = '0;
    dbus_req     = 1'b0;
    dbus_write   = 1'b0;
    dbus_addr    = '0;
    dbus_wdata   = '0;
    dbus_rd_mask = '0;
    dbus_wr_mask = '0;
    key          = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("o_ibus_ack", DATA_W'(ibus_ack), '0);
    check_value("o_dbus_ack", DATA_W'(dbus_ack), '0);
    check_value("o_led", DATA_W'(led), '0);

    fd = $fopen("tb/soc_tests.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("the test file tb/soc_tests.txt could not be opened");
    end
    else
    begin
      while (!at_end)
      begin
        if ($fgets(line, fd) == 0)
          at_end = 1'b1;
        else
        begin
          line_no++;
          if (line.len() > 2 && line.getc(0) != "#")
            run_test_line(line, line_no);
        end
      end
      $fclose(fd);
    end

    repeat (2) @(posedge clk);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/soc_tests.txt
# act port addr data rd_mask wr_mask expected (hex)
# act: w write, r read, k set keys, o check leds, q queue a tie read, g run tie (port wins first)
q d 80000000 00000000 f 0 00000000
q i 40000000 00000000 f 0 00000000
g d 00000000 00000000 0 0 00000000
w d 00000000 11223344 f f 00000000
w d 00000004 a5a5a5a5 f f 00000000
w d 00000008 deadbeef f f 00000000
w d 0000000c 01234567 f f 00000000
r d 00000000 00000000 f 0 11223344
r d 00000004 00000000 f 0 a5a5a5a5
r i 00000008 00000000 f 0 deadbeef
r i 0000000c 00000000 f 0 01234567
w d 00000000 ffeeddcc f 5 00000000
r d 00000000 00000000 f 0 11ee33cc
w d 00000004 00000000 f 8 00000000
r i 00000004 00000000 f 0 00a5a5a5
r d 00000008 00000000 6 0 00adbe00
r d 0000000c 00000000 9 0 01000067
r d 00000400 00000000 f 0 11ee33cc
w d 80000000 0000005a f 1 00000000
o d 00000000 00000000 0 0 0000005a
r d 80000010 00000000 f 0 0000005a
w d 80000000 000000ff f e 00000000
o d 00000000 00000000 0 0 0000005a
r i 80000000 00000000 f 0 0000005a
r d c0000000 00000000 f 0 00000000
k d 00000000 00000003 0 0 00000000
r d c0000000 00000000 f 0 0000000f
w d c0000000 0000000c f 1 00000000
r d c0000000 00000000 f 0 00000003
k d 00000000 00000001 0 0 00000000
r i c0000000 00000000 f 0 00000001
k d 00000000 00000003 0 0 00000000
r d c0000000 00000000 f 0 0000000b
w d 40000000 cafef00d f f 00000000
r d 40000000 00000000 f 0 00000000
r i 40000004 00000000 f 0 00000000
o d 00000000 00000000 0 0 0000005a
r d 00000000 00000000 f 0 11ee33cc
q d 00000008 00000000 f 0 deadbeef
q i 0000000c 00000000 f 0 01234567
g i 00000000 00000000 0 0 00000000
q d 00000000 00000000 3 0 000033cc
q i 00000004 00000000 f 0 00a5a5a5
g i 00000000 00000000 0 0 00000000
r i 00000008 00000000 f 0 deadbeef
q d 80000000 00000000 f 0 0000005a
q i c0000000 00000000 f 0 0000000b
g d 00000000 00000000 0 0 00000000

//--- flist.f
src/bus_pkg.sv
src/bus_arbiter.sv
src/bus_decoder.sv
src/soc_ram.sv
src/led_reg.sv
src/key_port.sv
src/soc_top.sv
tb/tb_soc_top.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_soc_top with Verilator, run it, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module tb_soc_top -f flist.f
	./obj_dir/Vtb_soc_top > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Finished with no errors" $(LOG) || (echo "simulation failed"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
